// File: common/controller_config.svh
`ifndef CONTROLLER_CONFIG_SVH
`define CONTROLLER_CONFIG_SVH

//////////////////////////////////////////////////
// Bus geometry
//////////////////////////////////////////////////

`define AXI_ADDR_WIDTH 16
`define AXI_DATA_WIDTH 32

//////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////

// Write-only, bit 0 holds the core in reset
`define REG_CONTROL 16'h0000

// Read-only view of the core status word
`define REG_STATUS 16'h0004

`define CORE_RST_BIT 0 // Control bit that drives core_rst

`endif

// File: common/axi_pkg.sv
`include "controller_config.svh"

package axi_pkg;

    // Response code of the B and R channels
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00; // The only code this slave returns

    // One accepted write, valid for a single bus cycle while strobe is high
    typedef struct packed {
        logic                       strobe;
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [`AXI_DATA_WIDTH-1:0] data;
    } reg_write_t;

    // Read address as seen by the register file
    typedef struct packed {
        logic                       strobe;
        logic [`AXI_ADDR_WIDTH-1:0] addr;
    } reg_read_t;

endpackage

// File: common/core_pkg.sv
package core_pkg;

    localparam int CYCLE_BITS = 24;

    // Status word reported by the core, running flag in the top bit
    typedef struct packed {
        logic                  running;
        logic [6:0]            reserved; // Always zero
        logic [CYCLE_BITS-1:0] cycles;
    } core_status_t;

endpackage

// File: controller/axi_lite_slave.sv
`timescale 1ns/100ps

`include "controller_config.svh"

module axi_lite_slave (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARSTN,

    input  logic [`AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR,
    input  logic                       S_AXI_AWVALID,
    output logic                       S_AXI_AWREADY,

    input  logic [`AXI_DATA_WIDTH-1:0] S_AXI_WDATA,
    input  logic                       S_AXI_WVALID,
    output logic                       S_AXI_WREADY,

    output axi_pkg::axi_resp_t         S_AXI_BRESP,
    output logic                       S_AXI_BVALID,
    input  logic                       S_AXI_BREADY,

    input  logic [`AXI_ADDR_WIDTH-1:0] S_AXI_ARADDR,
    input  logic                       S_AXI_ARVALID,
    output logic                       S_AXI_ARREADY,

    output logic [`AXI_DATA_WIDTH-1:0] S_AXI_RDATA,
    output axi_pkg::axi_resp_t         S_AXI_RRESP,
    output logic                       S_AXI_RVALID,
    input  logic                       S_AXI_RREADY,

    output axi_pkg::reg_write_t        wr,
    output axi_pkg::reg_read_t         rd,
    input  logic [`AXI_DATA_WIDTH-1:0] rdata
);

    import axi_pkg::*;

    logic wr_accept;
    logic rd_accept;

    assign wr_accept = S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WREADY && S_AXI_WVALID;
    assign rd_accept = S_AXI_ARREADY && S_AXI_ARVALID;

    //////////////////////////////////////////////////
    // Write channels
    //////////////////////////////////////////////////

    // Address and data are taken together, so one ready pulse serves both
    always_ff @(posedge S_AXI_ACLK) begin
        if (S_AXI_ARSTN == 1'b0) begin
            S_AXI_AWREADY <= 1'b0;
            S_AXI_WREADY  <= 1'b0;
        end else if (!S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID && !S_AXI_BVALID) begin
            S_AXI_AWREADY <= 1'b1;
            S_AXI_WREADY  <= 1'b1;
        end else begin
            S_AXI_AWREADY <= 1'b0;
            S_AXI_WREADY  <= 1'b0;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (S_AXI_ARSTN == 1'b0) begin
            S_AXI_BVALID <= 1'b0;
        end else if (wr_accept) begin
            S_AXI_BVALID <= 1'b1;
        end else if (S_AXI_BREADY) begin
            S_AXI_BVALID <= 1'b0;
        end
    end

    // Strobe is high exactly in the cycle the handshake completes
    always_comb begin
        wr.strobe = wr_accept;
        wr.addr   = S_AXI_AWADDR;
        wr.data   = S_AXI_WDATA;
    end

    assign S_AXI_BRESP = RESP_OKAY;

    //////////////////////////////////////////////////
    // Read channels
    //////////////////////////////////////////////////

    always_ff @(posedge S_AXI_ACLK) begin
        if (S_AXI_ARSTN == 1'b0) begin
            S_AXI_ARREADY <= 1'b0;
        end else begin
            S_AXI_ARREADY <= !S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (S_AXI_ARSTN == 1'b0) begin
            S_AXI_RVALID <= 1'b0;
        end else if (rd_accept) begin
            S_AXI_RVALID <= 1'b1;
        end else if (S_AXI_RREADY) begin
            S_AXI_RVALID <= 1'b0;
        end
    end

    // Held until the host takes it
    always_ff @(posedge S_AXI_ACLK) begin
        if (rd_accept) begin
            S_AXI_RDATA <= rdata;
        end
    end

    always_comb begin
        rd.strobe = rd_accept;
        rd.addr   = S_AXI_ARADDR;
    end

    assign S_AXI_RRESP = RESP_OKAY;

endmodule

// File: controller/sasanqua_controller.sv
`timescale 1ns/100ps

`include "controller_config.svh"

module sasanqua_controller (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARSTN,
    input  logic                       clk,

    input  axi_pkg::reg_write_t        wr,
    input  axi_pkg::reg_read_t         rd,
    output logic [`AXI_DATA_WIDTH-1:0] rdata,

    output logic                       core_rst,
    input  core_pkg::core_status_t     status
);

    import core_pkg::*;

    logic         core_hold; // Control register, only bit 0 is implemented
    logic [1:0]   rst_sync;
    core_status_t status_meta;
    core_status_t status_sync;

    //////////////////////////////////////////////////
    // Bus to core
    //////////////////////////////////////////////////

    always_ff @(posedge S_AXI_ACLK) begin
        if (S_AXI_ARSTN == 1'b0) begin
            core_hold <= 1'b0;
        end else if (wr.strobe && wr.addr == `REG_CONTROL) begin
            core_hold <= wr.data[`CORE_RST_BIT];
        end
    end

    // Two flops in the core clock domain
    always_ff @(posedge clk) begin
        if (S_AXI_ARSTN == 1'b0) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], core_hold};
        end
    end

    assign core_rst = rst_sync[1];

    //////////////////////////////////////////////////
    // Core to bus
    //////////////////////////////////////////////////

    always_ff @(posedge S_AXI_ACLK) begin
        status_meta <= status;
        status_sync <= status_meta;
    end

    // Control offset is write-only and reads back as zero like any hole
    always_comb begin
        if (rd.strobe && rd.addr == `REG_STATUS) begin
            rdata = status_sync;
        end else begin
            rdata = '0;
        end
    end

endmodule

// File: src/cycle_engine.sv
`timescale 1ns/100ps

module cycle_engine (
    input  logic                   clk,
    input  logic                   S_AXI_ARSTN,
    input  logic                   core_rst,
    output core_pkg::core_status_t status
);

    import core_pkg::*;

    logic                  running;
    logic [CYCLE_BITS-1:0] cycles;

    //////////////////////////////////////////////////
    // Cycle counter
    //////////////////////////////////////////////////

    // Either reset clears the core, the bus reset is sampled on clk here
    always_ff @(posedge clk) begin
        if (S_AXI_ARSTN == 1'b0 || core_rst) begin
            running <= 1'b0;
            cycles  <= '0;
        end else begin
            running <= 1'b1;
            cycles  <= cycles + 1'b1; // Wraps at 24 bits
        end
    end

    always_comb begin
        status          = '0;
        status.running  = running;
        status.cycles   = cycles;
    end

endmodule

// File: src/sasanqua_subsystem_top.sv
`timescale 1ns/100ps

`include "controller_config.svh"

module sasanqua_subsystem_top (
    input  logic                       clk,

    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARSTN,

    input  logic [`AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR,
    input  logic                       S_AXI_AWVALID,
    output logic                       S_AXI_AWREADY,

    input  logic [`AXI_DATA_WIDTH-1:0] S_AXI_WDATA,
    input  logic                       S_AXI_WVALID,
    output logic                       S_AXI_WREADY,

    output axi_pkg::axi_resp_t         S_AXI_BRESP,
    output logic                       S_AXI_BVALID,
    input  logic                       S_AXI_BREADY,

    input  logic [`AXI_ADDR_WIDTH-1:0] S_AXI_ARADDR,
    input  logic                       S_AXI_ARVALID,
    output logic                       S_AXI_ARREADY,

    output logic [`AXI_DATA_WIDTH-1:0] S_AXI_RDATA,
    output axi_pkg::axi_resp_t         S_AXI_RRESP,
    output logic                       S_AXI_RVALID,
    input  logic                       S_AXI_RREADY
);

    import axi_pkg::*;
    import core_pkg::*;

    reg_write_t                 wr;
    reg_read_t                  rd;
    logic [`AXI_DATA_WIDTH-1:0] rdata;
    logic                       core_rst;
    core_status_t               status;

    // Bus front end
    axi_lite_slave i_axi_lite_slave (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARSTN  (S_AXI_ARSTN),
        .S_AXI_AWADDR (S_AXI_AWADDR),
        .S_AXI_AWVALID(S_AXI_AWVALID),
        .S_AXI_AWREADY(S_AXI_AWREADY),
        .S_AXI_WDATA  (S_AXI_WDATA),
        .S_AXI_WVALID (S_AXI_WVALID),
        .S_AXI_WREADY (S_AXI_WREADY),
        .S_AXI_BRESP  (S_AXI_BRESP),
        .S_AXI_BVALID (S_AXI_BVALID),
        .S_AXI_BREADY (S_AXI_BREADY),
        .S_AXI_ARADDR (S_AXI_ARADDR),
        .S_AXI_ARVALID(S_AXI_ARVALID),
        .S_AXI_ARREADY(S_AXI_ARREADY),
        .S_AXI_RDATA  (S_AXI_RDATA),
        .S_AXI_RRESP  (S_AXI_RRESP),
        .S_AXI_RVALID (S_AXI_RVALID),
        .S_AXI_RREADY (S_AXI_RREADY),
        .wr           (wr),
        .rd           (rd),
        .rdata        (rdata)
    );

    sasanqua_controller i_sasanqua_controller (
        .S_AXI_ACLK (S_AXI_ACLK),
        .S_AXI_ARSTN(S_AXI_ARSTN),
        .clk        (clk),
        .wr         (wr),
        .rd         (rd),
        .rdata      (rdata),
        .core_rst   (core_rst),
        .status     (status)
    );

    cycle_engine i_cycle_engine (
        .clk        (clk),
        .S_AXI_ARSTN(S_AXI_ARSTN),
        .core_rst   (core_rst),
        .status     (status)
    );

endmodule

// File: tests/tb_sasanqua.sv
`timescale 1ns/100ps

`include "controller_config.svh"

module tb_sasanqua;

    import core_pkg::*;

    localparam int TIMEOUT   = 100; // Bus cycles allowed for any single wait
    localparam int MAX_POLLS = 20;  // Status reads allowed while waiting for the core

    logic                       clk;
    logic                       S_AXI_ACLK;
    logic                       S_AXI_ARSTN;
    logic [`AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR;
    logic                       S_AXI_AWVALID;
    logic                       S_AXI_AWREADY;
    logic [`AXI_DATA_WIDTH-1:0] S_AXI_WDATA;
    logic                       S_AXI_WVALID;
    logic                       S_AXI_WREADY;
    logic [1:0]                 S_AXI_BRESP;
    logic                       S_AXI_BVALID;
    logic                       S_AXI_BREADY;
    logic [`AXI_ADDR_WIDTH-1:0] S_AXI_ARADDR;
    logic                       S_AXI_ARVALID;
    logic                       S_AXI_ARREADY;
    logic [`AXI_DATA_WIDTH-1:0] S_AXI_RDATA;
    logic [1:0]                 S_AXI_RRESP;
    logic                       S_AXI_RVALID;
    logic                       S_AXI_RREADY;

    int     value_errors;
    int     timeout_errors;
    integer seed;

    sasanqua_subsystem_top i_sasanqua_subsystem_top (
        .clk          (clk),
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARSTN  (S_AXI_ARSTN),
        .S_AXI_AWADDR (S_AXI_AWADDR),
        .S_AXI_AWVALID(S_AXI_AWVALID),
        .S_AXI_AWREADY(S_AXI_AWREADY),
        .S_AXI_WDATA  (S_AXI_WDATA),
        .S_AXI_WVALID (S_AXI_WVALID),
        .S_AXI_WREADY (S_AXI_WREADY),
        .S_AXI_BRESP  (S_AXI_BRESP),
        .S_AXI_BVALID (S_AXI_BVALID),
        .S_AXI_BREADY (S_AXI_BREADY),
        .S_AXI_ARADDR (S_AXI_ARADDR),
        .S_AXI_ARVALID(S_AXI_ARVALID),
        .S_AXI_ARREADY(S_AXI_ARREADY),
        .S_AXI_RDATA  (S_AXI_RDATA),
        .S_AXI_RRESP  (S_AXI_RRESP),
        .S_AXI_RVALID (S_AXI_RVALID),
        .S_AXI_RREADY (S_AXI_RREADY)
    );

    always #4 S_AXI_ACLK = ~S_AXI_ACLK;
    always #5 clk = ~clk; // Core clock runs unrelated to the bus clock

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic note_timeout(input logic done, input string what);
        assert (done) else begin
            timeout_errors++;
            $display("Timeout: %s", what);
        end
    endtask

    task automatic status_running(input logic [31:0] word, input string name);
        core_status_t st;
        st = word;
        compare_word({name, " running"}, 32'h1, 32'(st.running));
        compare_word({name, " reserved"}, 32'h0, 32'(st.reserved));
    endtask

    task automatic cycles_advance(input logic [31:0] first, input logic [31:0] second,
                                  input string name);
        core_status_t a;
        core_status_t b;
        logic [23:0]  step;
        a = first;
        b = second;
        step = b.cycles - a.cycles; // The difference is modulo 2**24 and survives a wrap
        assert (step != 24'h0 && step < 24'h800000) else begin
            value_errors++;
            $display("error %s: expected cycles above %h, actual %h", name, a.cycles, b.cycles);
        end
    endtask

    //////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////

    // Entered and left just after a falling edge
    task automatic wait_write_accept(input string name);
        int count;
        count = 0;
        while (!S_AXI_AWREADY && count < TIMEOUT) begin
            @(negedge S_AXI_ACLK);
            count++;
        end
        note_timeout(S_AXI_AWREADY, {"write address never accepted in ", name});
        compare_word({name, " wready"}, 32'h1, 32'(S_AXI_WREADY));
        @(negedge S_AXI_ACLK); // The accepting edge has passed
    endtask

    task automatic take_write_response(input int delay, input string name);
        int count;
        count = 0;
        while (!S_AXI_BVALID && count < TIMEOUT) begin
            @(negedge S_AXI_ACLK);
            count++;
        end
        note_timeout(S_AXI_BVALID, {"no write response in ", name});
        compare_word({name, " bresp"}, 32'h0, 32'(S_AXI_BRESP)); // OKAY
        repeat (delay) begin
            @(negedge S_AXI_ACLK);
            compare_word({name, " bvalid held"}, 32'h1, 32'(S_AXI_BVALID));
        end
        S_AXI_BREADY = 1'b1;
        @(negedge S_AXI_ACLK);
        S_AXI_BREADY = 1'b0;
        compare_word({name, " bvalid cleared"}, 32'h0, 32'(S_AXI_BVALID));
    endtask

    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                             input int delay, input string name);
        S_AXI_AWADDR  = addr;
        S_AXI_WDATA   = data;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        wait_write_accept(name);
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        take_write_response(delay, name);
    endtask

    task automatic axi_read(input logic [15:0] addr, input int delay, input string name,
                            output logic [31:0] data);
        int count;
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        count = 0;
        while (!S_AXI_ARREADY && count < TIMEOUT) begin
            @(negedge S_AXI_ACLK);
            count++;
        end
        note_timeout(S_AXI_ARREADY, {"read address never accepted in ", name});
        @(negedge S_AXI_ACLK);
        S_AXI_ARVALID = 1'b0;
        count = 0;
        while (!S_AXI_RVALID && count < TIMEOUT) begin
            @(negedge S_AXI_ACLK);
            count++;
        end
        note_timeout(S_AXI_RVALID, {"no read data in ", name});
        data = S_AXI_RDATA;
        compare_word({name, " rresp"}, 32'h0, 32'(S_AXI_RRESP)); // OKAY
        repeat (delay) begin
            @(negedge S_AXI_ACLK);
            compare_word({name, " rvalid held"}, 32'h1, 32'(S_AXI_RVALID));
            compare_word({name, " rdata held"}, data, S_AXI_RDATA);
        end
        S_AXI_RREADY = 1'b1;
        @(negedge S_AXI_ACLK);
        S_AXI_RREADY = 1'b0;
        compare_word({name, " rvalid cleared"}, 32'h0, 32'(S_AXI_RVALID));
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic wait_core_running(input string name);
        logic [31:0] data;
        int          polls;
        polls = 0;
        axi_read(`REG_STATUS, 0, name, data);
        while (!data[31] && polls < MAX_POLLS) begin
            axi_read(`REG_STATUS, 0, name, data);
            polls++;
        end
        note_timeout(data[31], {"core never reported running in ", name});
    endtask

    task automatic core_runs_after_reset();
        logic [31:0] first;
        logic [31:0] second;
        wait_core_running("run after reset");
        axi_read(`REG_STATUS, 0, "run after reset", first);
        axi_read(`REG_STATUS, 0, "run after reset", second);
        status_running(first, "run after reset first");
        status_running(second, "run after reset second");
        cycles_advance(first, second, "run after reset");
    endtask

    task automatic core_held_in_reset();
        logic [31:0] data;
        int          polls;
        axi_write(`REG_CONTROL, 32'h1, 0, "core reset write");
        polls = 0;
        axi_read(`REG_STATUS, 0, "core reset", data);
        while (data != 32'h0 && polls < MAX_POLLS) begin
            axi_read(`REG_STATUS, 0, "core reset", data);
            polls++;
        end
        note_timeout(data == 32'h0, "status never cleared while the core is held");
        repeat (3) begin
            axi_read(`REG_STATUS, 0, "core reset", data);
            compare_word("core reset status", 32'h0, data);
        end
    endtask

    task automatic core_released();
        logic [31:0] first;
        logic [31:0] second;
        axi_write(`REG_CONTROL, 32'h0, 0, "release write");
        wait_core_running("release");
        axi_read(`REG_STATUS, 0, "release", first);
        axi_read(`REG_STATUS, 0, "release", second);
        status_running(first, "release first");
        status_running(second, "release second");
        cycles_advance(first, second, "release");
    endtask

    task automatic address_decoding();
        logic [31:0] data;
        axi_read(`REG_CONTROL, 0, "control read", data);
        compare_word("control read", 32'h0, data);
        axi_read(16'h0010, 0, "unmapped read", data);
        compare_word("unmapped read", 32'h0, data);
        axi_write(16'h0010, 32'h1, 0, "unmapped write");
        // A stray core reset needs a few core clocks to show in the status word
        repeat (3) begin
            axi_read(`REG_STATUS, 0, "unmapped write status", data);
            status_running(data, "unmapped write status");
        end
    endtask

    task automatic response_backpressure();
        logic [31:0] data;
        int          delay;
        repeat (8) begin
            delay = {$random(seed)} % 8;
            data  = $random(seed);
            axi_write(16'h0010, data, delay, "write backpressure");
            delay = {$random(seed)} % 8;
            axi_read(`REG_STATUS, delay, "read backpressure", data);
            status_running(data, "read backpressure");
        end
    endtask

    // The second write stays offered while the first response waits
    task automatic write_blocked_by_response();
        int hold;
        hold = {$random(seed)} % 8 + 1;
        S_AXI_AWADDR  = 16'h0010;
        S_AXI_WDATA   = 32'h0;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        wait_write_accept("overlap first write");
        S_AXI_WDATA = 32'h1;
        repeat (hold) begin
            @(negedge S_AXI_ACLK);
            compare_word("overlap awready", 32'h0, 32'(S_AXI_AWREADY));
            compare_word("overlap wready", 32'h0, 32'(S_AXI_WREADY));
            compare_word("overlap bvalid", 32'h1, 32'(S_AXI_BVALID));
        end
        take_write_response(0, "overlap first response");
        wait_write_accept("overlap second write");
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        take_write_response(0, "overlap second response");
    endtask

    initial begin
        value_errors   = 0;
        timeout_errors = 0;
        seed           = 32'h2169f14f;
        clk            = 1'b0;
        S_AXI_ACLK     = 1'b0;
        S_AXI_ARSTN    = 1'b0;
        S_AXI_AWADDR   = '0;
        S_AXI_AWVALID  = 1'b0;
        S_AXI_WDATA    = '0;
        S_AXI_WVALID   = 1'b0;
        S_AXI_BREADY   = 1'b0;
        S_AXI_ARADDR   = '0;
        S_AXI_ARVALID  = 1'b0;
        S_AXI_RREADY   = 1'b0;

        repeat (4) @(negedge S_AXI_ACLK);
        compare_word("reset awready", 32'h0, 32'(S_AXI_AWREADY));
        compare_word("reset wready", 32'h0, 32'(S_AXI_WREADY));
        compare_word("reset bvalid", 32'h0, 32'(S_AXI_BVALID));
        compare_word("reset arready", 32'h0, 32'(S_AXI_ARREADY));
        compare_word("reset rvalid", 32'h0, 32'(S_AXI_RVALID));
        S_AXI_ARSTN = 1'b1;

        core_runs_after_reset();
        core_held_in_reset();
        core_released();
        address_decoding();
        response_backpressure();
        write_blocked_by_response();

        $display("%0d value errors, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+common
common/axi_pkg.sv
common/core_pkg.sv
controller/axi_lite_slave.sv
controller/sasanqua_controller.sv
src/cycle_engine.sv
src/sasanqua_subsystem_top.sv
tests/tb_sasanqua.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert --top-module tb_sasanqua -f all.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Build failed with status $status"
    exit 1
fi

output="$(./obj_dir/Vtb_sasanqua)"
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
